// ==== common/memtest_pkg.sv ====
package memtest_pkg;

    // ram geometry
    localparam int addr_width = 10;
    localparam int data_width = 16;

    // host bus
    localparam int axi_addr_width = 16;
    localparam int axi_data_width = 32;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // register byte offsets
    localparam logic [axi_addr_width-1:0] reg_ctrl      = 16'h0000;
    localparam logic [axi_addr_width-1:0] reg_status    = 16'h0004;
    localparam logic [axi_addr_width-1:0] reg_seed      = 16'h0008;
    localparam logic [axi_addr_width-1:0] reg_fail_addr = 16'h000c;
    localparam logic [axi_addr_width-1:0] reg_fail_data = 16'h0010;
    localparam logic [axi_addr_width-1:0] win_base      = 16'h1000; // one word per 4 bytes

    localparam logic [data_width-1:0] seed_reset = 16'h1234;

    typedef enum logic [1:0] {
        op_full,
        op_write_only,
        op_read_only
    } test_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_write,
        st_read,
        st_end
    } tester_state_e;

endpackage

// ==== hdl/ram_block.sv ====
`timescale 1ns/1ns

module ram_block
    import memtest_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    output logic                  ack,
    input  logic                  we,
    input  logic [addr_width-1:0] addr,
    input  logic [data_width-1:0] wdata,
    output logic [data_width-1:0] rdata
);

    logic [data_width-1:0] mem [2**addr_width];
    logic pending;

    assign pending = (req != ack);

    always_ff @(posedge clk) begin
        if (reset)
            ack <= 1'b0;
        else if (pending)
            ack <= req; // finishes the access
    end

    // storage and read data
    always_ff @(posedge clk) begin
        if (pending) begin
            if (we)
                mem[addr] <= wdata;
            else
                rdata <= mem[addr];
        end
    end

endmodule

// ==== hdl/mem_arbiter.sv ====
`timescale 1ns/1ns

module mem_arbiter
    import memtest_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  t_req,
    output logic                  t_ack,
    input  logic                  t_we,
    input  logic [addr_width-1:0] t_addr,
    input  logic [data_width-1:0] t_wdata,
    output logic [data_width-1:0] t_rdata,
    input  logic                  h_req,
    output logic                  h_ack,
    input  logic                  h_we,
    input  logic [addr_width-1:0] h_addr,
    input  logic [data_width-1:0] h_wdata,
    output logic [data_width-1:0] h_rdata,
    output logic                  m_req,
    input  logic                  m_ack,
    output logic                  m_we,
    output logic [addr_width-1:0] m_addr,
    output logic [data_width-1:0] m_wdata,
    input  logic [data_width-1:0] m_rdata
);

    logic t_ack_q;
    logic h_ack_q;
    logic active;     // a request is forwarded to the ram
    logic owner_host;
    logic m_done;

    assign m_done = active && (m_req == m_ack);

    // ack goes back in the same cycle the ram answers
    assign t_ack   = t_ack_q ^ (m_done && !owner_host);
    assign h_ack   = h_ack_q ^ (m_done && owner_host);
    assign t_rdata = m_rdata;
    assign h_rdata = m_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            t_ack_q <= 1'b0;
            h_ack_q <= 1'b0;
            active  <= 1'b0;
            m_req   <= 1'b0;
        end else if (m_done) begin
            active <= 1'b0;
            if (owner_host)
                h_ack_q <= ~h_ack_q;
            else
                t_ack_q <= ~t_ack_q;
        end else if (!active) begin
            if (t_req != t_ack_q) begin // tester wins ties
                owner_host <= 1'b0;
                m_we       <= t_we;
                m_addr     <= t_addr;
                m_wdata    <= t_wdata;
                m_req      <= ~m_req;
                active     <= 1'b1;
            end else if (h_req != h_ack_q) begin
                owner_host <= 1'b1;
                m_we       <= h_we;
                m_addr     <= h_addr;
                m_wdata    <= h_wdata;
                m_req      <= ~m_req;
                active     <= 1'b1;
            end
        end
    end

    a_one_outstanding: assert property (@(posedge clk) disable iff (reset)
        (m_req != $past(m_req)) |-> $past(m_req == m_ack));

endmodule

// ==== tester/mem_tester.sv ====
`timescale 1ns/1ns

module mem_tester
    import memtest_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  test_op_e              op,
    input  logic [data_width-1:0] seed,
    output logic                  busy,
    output logic                  done,
    output logic                  fail,
    output logic [addr_width-1:0] fail_addr,
    output logic [data_width-1:0] fail_data,
    output logic                  req,
    input  logic                  ack,
    output logic                  we,
    output logic [addr_width-1:0] addr,
    output logic [data_width-1:0] wdata,
    input  logic [data_width-1:0] rdata
);

    tester_state_e state;
    test_op_e op_q;
    logic [data_width-1:0] seed_q;
    logic [data_width-1:0] expected;
    logic idle_port;
    logic last_addr;

    assign idle_port = (req == ack);
    assign last_addr = addr[addr_width-1]; // 512 is the end of the walk

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            busy  <= 1'b0;
            done  <= 1'b0;
            fail  <= 1'b0;
            req   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        busy   <= 1'b1;
                        done   <= 1'b0;
                        fail   <= 1'b0;
                        op_q   <= op;
                        seed_q <= seed;
                        addr   <= addr_width'(1);
                        req    <= ~req;
                        if (op == op_read_only) begin
                            state    <= st_read;
                            we       <= 1'b0;
                            expected <= seed;
                        end else begin
                            state <= st_write;
                            we    <= 1'b1;
                            wdata <= seed;
                        end
                    end
                end
                st_write: begin
                    if (idle_port) begin
                        if (last_addr) begin
                            if (op_q == op_write_only) begin
                                state <= st_end;
                            end else begin
                                // restart the walk for the read-back
                                state    <= st_read;
                                we       <= 1'b0;
                                addr     <= addr_width'(1);
                                expected <= seed_q;
                                req      <= ~req;
                            end
                        end else begin
                            addr  <= addr << 1;
                            wdata <= {wdata[data_width-2:0], wdata[data_width-1]};
                            req   <= ~req;
                        end
                    end
                end
                st_read: begin
                    if (idle_port) begin
                        if (rdata != expected) begin
                            fail      <= 1'b1; // keep the first miscompare only
                            fail_addr <= addr;
                            fail_data <= rdata;
                            state     <= st_end;
                        end else if (last_addr) begin
                            state <= st_end;
                        end else begin
                            addr     <= addr << 1;
                            expected <= {expected[data_width-2:0], expected[data_width-1]};
                            req      <= ~req;
                        end
                    end
                end
                st_end: begin
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    a_addr_onehot: assert property (@(posedge clk) disable iff (reset)
        (req != ack) |-> $onehot(addr));

endmodule

// ==== hdl/mem_test_regs.sv ====
`timescale 1ns/1ns

module mem_test_regs
    import memtest_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic [axi_addr_width-1:0]   awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [axi_data_width-1:0]   wdata,
    input  logic [axi_data_width/8-1:0] wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [axi_addr_width-1:0]   araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [axi_data_width-1:0]   rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,
    output logic                        start,
    output test_op_e                    op,
    output logic [data_width-1:0]       seed,
    input  logic                        busy,
    input  logic                        done,
    input  logic                        fail,
    input  logic [addr_width-1:0]       fail_addr,
    input  logic [data_width-1:0]       fail_data,
    output logic                        host_req,
    input  logic                        host_ack,
    output logic                        host_we,
    output logic [addr_width-1:0]       host_addr,
    output logic [data_width-1:0]       host_wdata,
    input  logic [data_width-1:0]       host_rdata
);

    logic win_pend;   // window access waiting for the ram
    logic win_write;
    logic wr_accept;
    logic rd_accept;
    logic host_done;

    function automatic logic in_window(input logic [axi_addr_width-1:0] a);
        return (a >= win_base) && (a < win_base + (4 << addr_width));
    endfunction

    function automatic logic is_reg(input logic [axi_addr_width-1:0] a);
        return (a == reg_ctrl) || (a == reg_status) || (a == reg_seed) ||
               (a == reg_fail_addr) || (a == reg_fail_data);
    endfunction

    function automatic logic [axi_data_width-1:0] read_reg(input logic [axi_addr_width-1:0] a);
        logic [axi_data_width-1:0] v;
        v = '0;
        case (a)
            reg_ctrl:      v[2:1] = op;
            reg_status:    v[2:0] = {fail, done, busy};
            reg_seed:      v[data_width-1:0] = seed;
            reg_fail_addr: v[addr_width-1:0] = fail_addr;
            reg_fail_data: v[data_width-1:0] = fail_data;
            default:       v = '0;
        endcase
        return v;
    endfunction

    // one access at a time towards the ram, writes first
    assign wr_accept = awvalid && wvalid && !bvalid && !win_pend;
    assign rd_accept = arvalid && !rvalid && !win_pend && !wr_accept;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign arready   = rd_accept;
    assign host_done = win_pend && (host_req == host_ack);

    always_ff @(posedge clk) begin
        if (reset) begin
            start    <= 1'b0;
            op       <= op_full;
            seed     <= seed_reset;
            bvalid   <= 1'b0;
            rvalid   <= 1'b0;
            host_req <= 1'b0;
            win_pend <= 1'b0;
        end else begin
            start <= 1'b0; // single cycle pulse
            if (bvalid && bready)
                bvalid <= 1'b0;
            if (rvalid && rready)
                rvalid <= 1'b0;

            if (wr_accept) begin
                if (in_window(awaddr)) begin
                    host_req   <= ~host_req;
                    host_we    <= 1'b1;
                    host_addr  <= awaddr[addr_width+1:2];
                    host_wdata <= wdata[data_width-1:0];
                    win_write  <= 1'b1;
                    win_pend   <= 1'b1;
                end else begin
                    bvalid <= 1'b1;
                    bresp  <= is_reg(awaddr) ? resp_okay : resp_slverr;
                    if (|wstrb) begin // zero strobes leave the registers alone
                        case (awaddr)
                            reg_ctrl: begin
                                op    <= test_op_e'(wdata[2:1]);
                                start <= wdata[0];
                            end
                            reg_seed: seed <= wdata[data_width-1:0];
                            default: ;
                        endcase
                    end
                end
            end

            if (rd_accept) begin
                if (in_window(araddr)) begin
                    host_req  <= ~host_req;
                    host_we   <= 1'b0;
                    host_addr <= araddr[addr_width+1:2];
                    win_write <= 1'b0;
                    win_pend  <= 1'b1;
                end else begin
                    rvalid <= 1'b1;
                    rresp  <= is_reg(araddr) ? resp_okay : resp_slverr;
                    rdata  <= read_reg(araddr);
                end
            end

            if (host_done) begin
                win_pend <= 1'b0;
                if (win_write) begin
                    bvalid <= 1'b1;
                    bresp  <= resp_okay;
                end else begin
                    rvalid <= 1'b1;
                    rresp  <= resp_okay;
                    rdata  <= axi_data_width'(host_rdata);
                end
            end
        end
    end

    a_no_aw_during_b: assert property (@(posedge clk) disable iff (reset)
        !(bvalid && awready));

endmodule

// ==== hdl/memtest_top.sv ====
`timescale 1ns/1ns

module memtest_top
    import memtest_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic [axi_addr_width-1:0]   awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [axi_data_width-1:0]   wdata,
    input  logic [axi_data_width/8-1:0] wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [axi_addr_width-1:0]   araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [axi_data_width-1:0]   rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready
);

    // tester control
    logic                  start;
    test_op_e              op;
    logic [data_width-1:0] seed;
    logic                  busy;
    logic                  done;
    logic                  fail;
    logic [addr_width-1:0] fail_addr;
    logic [data_width-1:0] fail_data;

    // host window port
    logic                  h_req, h_ack, h_we;
    logic [addr_width-1:0] h_addr;
    logic [data_width-1:0] h_wdata, h_rdata;

    // tester port
    logic                  t_req, t_ack, t_we;
    logic [addr_width-1:0] t_addr;
    logic [data_width-1:0] t_wdata, t_rdata;

    // ram port
    logic                  m_req, m_ack, m_we;
    logic [addr_width-1:0] m_addr;
    logic [data_width-1:0] m_wdata, m_rdata;

    mem_test_regs u_regs (
        .clk, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .start, .op, .seed, .busy, .done, .fail, .fail_addr, .fail_data,
        .host_req(h_req), .host_ack(h_ack), .host_we(h_we),
        .host_addr(h_addr), .host_wdata(h_wdata), .host_rdata(h_rdata)
    );

    mem_tester u_tester (
        .clk, .reset, .start, .op, .seed, .busy, .done, .fail, .fail_addr, .fail_data,
        .req(t_req), .ack(t_ack), .we(t_we), .addr(t_addr), .wdata(t_wdata), .rdata(t_rdata)
    );

    mem_arbiter u_arbiter (
        .clk, .reset,
        .t_req, .t_ack, .t_we, .t_addr, .t_wdata, .t_rdata,
        .h_req, .h_ack, .h_we, .h_addr, .h_wdata, .h_rdata,
        .m_req, .m_ack, .m_we, .m_addr, .m_wdata, .m_rdata
    );

    ram_block u_ram (
        .clk, .reset,
        .req(m_req), .ack(m_ack), .we(m_we), .addr(m_addr), .wdata(m_wdata), .rdata(m_rdata)
    );

endmodule

// ==== test/tb_memtest.sv ====
`timescale 1ns/1ns

module tb_memtest
    import memtest_pkg::*;
;

    // six tests, each well under 2000 cycles
    localparam int max_cycles = 20000;
    localparam int max_polls  = 600; // about 2 cycles per status read

    logic        clk;
    logic        reset;
    logic [15:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [15:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    int unsigned rng_seed;
    int          cycle_count = 0;

    memtest_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles)
            abort_run("timeout: the run went past the cycle limit");
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
            abort_run($sformatf("MISMATCH %s expected 0x%08h actual 0x%08h",
                                name, expected, actual));
    endtask

    function automatic logic [15:0] rotate_left(input logic [15:0] v, input int k);
        logic [15:0] r;
        r = v;
        repeat (k) r = {r[14:0], r[15]};
        return r;
    endfunction

    // called 10 ns after a rising edge, returns at the same offset
    task automatic axi_write(input logic [15:0] a, input logic [31:0] d,
                             output logic [1:0] resp);
        awaddr  = a;
        wdata   = d;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(posedge clk);
        while (!awready) @(posedge clk);
        check_value("wready with awready", 32'h1, {31'h0, wready});
        #10;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(posedge clk);
        while (!bvalid) @(posedge clk);
        resp = bresp;
        #10;
    endtask

    task automatic axi_read(input logic [15:0] a, output logic [31:0] d,
                            output logic [1:0] resp);
        araddr  = a;
        arvalid = 1'b1;
        @(posedge clk);
        while (!arready) @(posedge clk);
        #10;
        arvalid = 1'b0;
        @(posedge clk);
        while (!rvalid) @(posedge clk);
        d    = rdata;
        resp = rresp;
        #10;
    endtask

    task automatic wait_done(input string name);
        logic [31:0] status;
        logic [1:0]  resp;
        int          polls;
        polls = 0;
        axi_read(reg_status, status, resp);
        while (!status[1] && polls < max_polls) begin
            axi_read(reg_status, status, resp);
            polls++;
        end
        if (!status[1])
            abort_run($sformatf("%s: the tester never finished", name));
    endtask

    task automatic run_op(input logic [1:0] op, input logic [15:0] s, input string name);
        logic [1:0] resp;
        axi_write(reg_seed, {16'h0, s}, resp);
        check_value({name, " seed resp"}, resp_okay, resp);
        axi_write(reg_ctrl, {29'h0, op, 1'b1}, resp); // start bit
        check_value({name, " ctrl resp"}, resp_okay, resp);
        wait_done(name);
    endtask

    task automatic reset_values();
        logic [31:0] d;
        logic [1:0]  resp;
        axi_read(reg_status, d, resp);
        check_value("reset status", 32'h0, d);
        check_value("reset status resp", resp_okay, resp);
        axi_read(reg_seed, d, resp);
        check_value("reset seed", 32'h1234, d);
    endtask

    task automatic full_run();
        logic [31:0] d;
        logic [1:0]  resp;
        run_op(op_full, 16'($urandom), "full run");
        axi_read(reg_status, d, resp);
        check_value("full run status", 32'h2, d); // done only
    endtask

    task automatic window_round_trip();
        logic [9:0]  wa [8];
        logic [15:0] wd [8];
        logic [31:0] d;
        logic [1:0]  resp;
        int          i;
        for (i = 0; i < 8; i++) begin
            wa[i] = 10'(i * 128 + $urandom % 128); // distinct words
            wd[i] = 16'($urandom);
            axi_write(win_base + {4'h0, wa[i], 2'b00}, {16'h0, wd[i]}, resp);
            check_value("window write resp", resp_okay, resp);
        end
        for (i = 0; i < 8; i++) begin
            axi_read(win_base + {4'h0, wa[i], 2'b00}, d, resp);
            check_value("window read resp", resp_okay, resp);
            check_value("window read data", {16'h0, wd[i]}, d);
        end
    endtask

    task automatic write_only_pattern();
        logic [15:0] s;
        logic [31:0] d;
        logic [1:0]  resp;
        int          k;
        s = 16'($urandom);
        run_op(op_write_only, s, "write-only pattern");
        for (k = 0; k < addr_width; k++) begin
            axi_read(win_base + 16'(4 << k), d, resp);
            check_value("write-only pattern resp", resp_okay, resp);
            check_value("write-only pattern data", {16'h0, rotate_left(s, k)}, d);
        end
    endtask

    task automatic retention_failure();
        logic [15:0] s;
        logic [15:0] bad;
        logic [31:0] d;
        logic [1:0]  resp;
        s   = 16'($urandom);
        bad = ~rotate_left(s, 3);
        run_op(op_write_only, s, "retention write");
        axi_write(win_base + 16'd32, {16'h0, bad}, resp); // word 8
        check_value("retention corrupt resp", resp_okay, resp);
        run_op(op_read_only, s, "retention read");
        axi_read(reg_status, d, resp);
        check_value("retention status", 32'h6, d);
        axi_read(reg_fail_addr, d, resp);
        check_value("retention fail addr", 32'h8, d);
        axi_read(reg_fail_data, d, resp);
        check_value("retention fail data", {16'h0, bad}, d);
    endtask

    task automatic unmapped_offsets();
        logic [31:0] seed_before;
        logic [31:0] ctrl_before;
        logic [31:0] status_before;
        logic [31:0] d;
        logic [1:0]  resp;
        axi_read(reg_seed, seed_before, resp);
        axi_read(reg_ctrl, ctrl_before, resp);
        axi_read(reg_status, status_before, resp);
        axi_write(16'h2008, 32'h0000abcd, resp);
        check_value("unmapped write 0x2008", resp_slverr, resp);
        axi_write(16'h2000, 32'h00000007, resp); // would start if aliased
        check_value("unmapped write 0x2000", resp_slverr, resp);
        axi_write(16'hfffc, 32'hffffffff, resp);
        check_value("unmapped write 0xfffc", resp_slverr, resp);
        axi_read(16'h2000, d, resp);
        check_value("unmapped read 0x2000", resp_slverr, resp);
        axi_read(16'hfff0, d, resp);
        check_value("unmapped read 0xfff0", resp_slverr, resp);
        axi_read(reg_seed, d, resp);
        check_value("unmapped seed kept", seed_before, d);
        axi_read(reg_ctrl, d, resp);
        check_value("unmapped ctrl kept", ctrl_before, d);
        axi_read(reg_status, d, resp);
        check_value("unmapped status kept", status_before, d);
    endtask

    initial begin
        reset    = 1'b1;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b1;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b1;
        rng_seed = 32'hed24028b;
        rng_seed = $urandom(rng_seed);
        repeat (5) @(posedge clk);
        #10;
        reset = 1'b0;

        reset_values();
        full_run();
        window_round_trip();
        write_only_pattern();
        retention_failure();
        unmapped_offsets();

        $display("test passed");
        $finish;
    end

endmodule

// ==== tb.f ====
common/memtest_pkg.sv
hdl/ram_block.sv
hdl/mem_arbiter.sv
tester/mem_tester.sv
hdl/mem_test_regs.sv
hdl/memtest_top.sv
test/tb_memtest.sv

// ==== Bender.yml ====
package:
  name: memtest

sources:
  - common/memtest_pkg.sv
  - hdl/ram_block.sv
  - hdl/mem_arbiter.sv
  - tester/mem_tester.sv
  - hdl/mem_test_regs.sv
  - hdl/memtest_top.sv
  - target: test
    files:
      - test/tb_memtest.sv
